// File: filelist.f
verilog/board_pkg.sv
verilog/board_cmd_decoder.sv
verilog/board_store.sv
verilog/board_frame_sender.sv
verilog/uart_tx.sv
verilog/board_uart_top.sv
dv/uart_rx_model.sv
dv/board_uart_tb.sv

// File: dv/board_uart_tb.sv
`timescale 1ns/10ps
`default_nettype none

module board_uart_tb import board_pkg::*; ();

    localparam logic [7:0] EVENT_CODE   = 8'hAC;
    localparam int         PACKET_GAP   = 20;
    localparam int         CLKS_PER_BIT = 8;
    localparam int         FRAME_MARGIN = 256;  // per-byte handshake cycles.

    typedef struct packed {
        cmd_op_t    op;
        logic [3:0] row;
        logic [3:0] col;
        logic [3:0] value;
        logic       exp_err;
    } cmd_entry_t;

    logic        clock;
    logic        reset;
    logic        cmd_valid;
    cmd_op_t     cmd_op;
    logic [3:0]  cmd_row;
    logic [3:0]  cmd_col;
    logic [3:0]  cmd_value;
    wire         cmd_ready;
    wire         cmd_error;
    wire         frame_done;
    wire         serial_out;
    wire [7:0]   rx_data;
    wire         rx_valid;
    wire         framing_error;

    cmd_entry_t  cmd_table[$];
    logic [3:0]  ref_cells[CELL_COUNT];
    logic [7:0]  exp_bytes[$];
    logic [7:0]  rx_bytes[$];
    logic [15:0] lfsr_state;
    int          frames_sent;
    int          frames_checked;
    bit          table_built;

    board_uart_top #(
        .EVENT_CODE (EVENT_CODE),
        .PACKET_GAP (PACKET_GAP),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut_i (
        .clock (clock), .reset (reset), .cmd_valid (cmd_valid), .cmd_op (cmd_op),
        .cmd_row (cmd_row), .cmd_col (cmd_col), .cmd_value (cmd_value),
        .cmd_ready (cmd_ready), .cmd_error (cmd_error), .frame_done (frame_done),
        .serial_out (serial_out)
    );

    uart_rx_model #(.CLKS_PER_BIT (CLKS_PER_BIT)) rx_model_i (
        .clock (clock), .reset (reset), .serial_in (serial_out),
        .rx_data (rx_data), .rx_valid (rx_valid), .framing_error (framing_error)
    );

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    // x^16 + x^14 + x^13 + x^11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    function automatic logic rejected(input cmd_entry_t e);
        if (e.op == op_reserved)
            return 1'b1;
        return e.op == op_write_cell && (e.row > 8 || e.col > 8 || e.value > MAX_CELL_VALUE);
    endfunction

    task automatic add_row(input cmd_op_t op, input int row, input int col, input int value,
                           input logic exp_err);
        cmd_table.push_back({op, 4'(row), 4'(col), 4'(value), exp_err});
    endtask

    task automatic build_table();
        int row, col, value;
        add_row(op_send_board, 0, 0, 0, 0);    // empty board.
        add_row(op_write_cell, 0, 0, 1, 0);
        add_row(op_write_cell, 0, 1, 2, 0);
        add_row(op_write_cell, 8, 8, 9, 0);    // lands in the padded last byte.
        add_row(op_write_cell, 4, 5, 7, 0);
        add_row(op_send_board, 15, 15, 15, 0);
        add_row(op_write_cell, 9, 0, 1, 1);
        add_row(op_write_cell, 0, 12, 3, 1);
        add_row(op_write_cell, 2, 2, 10, 1);
        add_row(op_reserved, 1, 1, 1, 1);
        add_row(op_send_board, 0, 0, 0, 0);
        add_row(op_write_cell, 3, 3, 5, 0);    // held off by the running frame.
        add_row(op_write_cell, 0, 0, 6, 0);
        add_row(op_send_board, 0, 0, 0, 0);
        for (int i = 0; i < 12; i++) begin
            row = random_bits(4) % 9;
            col = random_bits(4) % 9;
            value = random_bits(4) % 10;
            add_row(op_write_cell, row, col, value, 0);
        end
        add_row(op_send_board, 0, 0, 0, 0);
        add_row(op_clear_board, 0, 0, 0, 0);
        add_row(op_send_board, 0, 0, 0, 0);
    endtask

    task automatic push_expected_frame();
        logic [3:0] low;
        exp_bytes.push_back(EVENT_CODE);
        for (int k = 1; k < FRAME_BYTES; k++) begin
            low = (2 * k - 1 < CELL_COUNT) ? ref_cells[2 * k - 1] : 4'd0;  // cell 81 is zero.
            exp_bytes.push_back({ref_cells[2 * k - 2], low});
        end
    endtask

    task automatic update_reference(input cmd_entry_t e);
        if (rejected(e))
            return;
        case (e.op)
            op_write_cell: ref_cells[e.row * GRID_COLS + e.col] = e.value;
            op_clear_board: begin
                foreach (ref_cells[i])
                    ref_cells[i] = '0;
            end
            op_send_board: begin
                push_expected_frame();
                frames_sent++;
            end
            default: ;
        endcase
    endtask

    // called 1 ns after a rising edge; ready is stable until the next one.
    task automatic apply_command(input cmd_entry_t e, input int index);
        logic accepted;
        cmd_valid = 1'b1;
        cmd_op    = e.op;
        cmd_row   = e.row;
        cmd_col   = e.col;
        cmd_value = e.value;
        accepted  = 1'b0;
        while (!accepted) begin
            accepted = cmd_ready;
            @(posedge clock);
            #1;
        end
        cmd_valid = 1'b0;
        assert (cmd_error === e.exp_err)
            else fail_run($sformatf("** Error at %0t ns: row %0d cmd_error is %b, expected %b",
                                    $time, index, cmd_error, e.exp_err));
    endtask

    task automatic check_frame();
        logic [7:0] expected;
        logic [7:0] got;
        assert (exp_bytes.size() >= FRAME_BYTES)
            else fail_run("frame_done pulsed although no frame was requested.");
        assert (rx_bytes.size() == FRAME_BYTES)
            else fail_run($sformatf("** Error at %0t ns: frame %0d has %0d bytes, expected %0d",
                                    $time, frames_checked, rx_bytes.size(), FRAME_BYTES));
        for (int k = 0; k < FRAME_BYTES; k++) begin
            expected = exp_bytes.pop_front();
            got = rx_bytes.pop_front();
            assert (got === expected)
                else fail_run($sformatf(
                    "** Error at %0t ns: frame %0d byte %0d is %02h, expected %02h",
                    $time, frames_checked, k, got, expected));
        end
        frames_checked++;
    endtask

    // mid-cycle sampling of the strobes.
    always @(negedge clock) begin
        if (rx_valid) begin
            assert (!framing_error)
                else fail_run($sformatf("** Error at %0t ns: bad start or stop bit", $time));
            rx_bytes.push_back(rx_data);
        end
        if (frame_done)
            check_frame();
    end

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        reset          = 1'b1;
        cmd_valid      = 1'b0;
        cmd_op         = op_write_cell;
        cmd_row        = '0;
        cmd_col        = '0;
        cmd_value      = '0;
        lfsr_state     = 16'd59045;
        frames_sent    = 0;
        frames_checked = 0;
        foreach (ref_cells[i])
            ref_cells[i] = '0;
        build_table();
        table_built = 1'b1;
        repeat (10) @(posedge clock);
        #1 reset = 1'b0;
        foreach (cmd_table[r]) begin
            apply_command(cmd_table[r], r);
            assert (frames_checked == frames_sent)
                else fail_run($sformatf("Command %0d was accepted during a frame.", r));
            update_reference(cmd_table[r]);
        end
        wait (frames_checked == frames_sent);
        repeat (PACKET_GAP + 20 * CLKS_PER_BIT) @(posedge clock);  // room for a stray byte.
        assert (rx_bytes.size() == 0)
            else fail_run("Bytes arrived on the serial line outside any frame.");
        $display("PASS: all tests");
        $finish;
    end

    // watchdog sized from the table.
    initial begin
        int sends;
        int limit;
        wait (table_built);
        sends = 0;
        foreach (cmd_table[r])
            sends += (cmd_table[r].op == op_send_board);
        limit = sends * (PACKET_GAP + FRAME_BYTES * 10 * CLKS_PER_BIT + FRAME_MARGIN)
                + cmd_table.size() * 10 + 10;
        repeat (limit) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles.", limit);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: dv/uart_rx_model.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_model #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire        clock,
    input  wire        reset,
    input  wire        serial_in,
    output logic [7:0] rx_data,
    output logic       rx_valid,       // one cycle per byte.
    output logic       framing_error   // qualified by rx_valid.
);

    logic [7:0] shift;
    logic       start_ok;
    logic       stop_ok;

    // 8N1 receive, each bit sampled at its middle.
    initial begin
        rx_data       = '0;
        rx_valid      = 1'b0;
        framing_error = 1'b0;
        wait (reset === 1'b0);
        forever begin
            @(negedge serial_in);
            repeat (CLKS_PER_BIT / 2) @(posedge clock);
            start_ok = (serial_in === 1'b0);  // no glitch.
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clock);
                shift[i] = serial_in;  // lsb first.
            end
            repeat (CLKS_PER_BIT) @(posedge clock);
            stop_ok       = (serial_in === 1'b1);
            rx_data       = shift;
            framing_error = !(start_ok && stop_ok);
            rx_valid      = 1'b1;
            @(posedge clock);
            rx_valid      = 1'b0;
            framing_error = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/board_uart_top.sv
`timescale 1ns/10ps
`default_nettype none

module board_uart_top import board_pkg::*; #(
    parameter logic [7:0] EVENT_CODE   = 8'hAC,
    parameter int         PACKET_GAP   = 1000,
    parameter int         CLKS_PER_BIT = 434
) (
    input  wire          clock,
    input  wire          reset,
    input  wire          cmd_valid,
    input  wire cmd_op_t cmd_op,
    input  wire [3:0]    cmd_row,
    input  wire [3:0]    cmd_col,
    input  wire [3:0]    cmd_value,
    output logic         cmd_ready,
    output logic         cmd_error,
    output logic         frame_done,
    output logic         serial_out
);

    logic                  cell_write_en;
    logic [6:0]            cell_index;
    logic [3:0]            cell_value;
    logic                  board_clear;
    logic                  send_start;
    logic                  sending;
    logic [BOARD_BITS-1:0] board;
    logic                  tx_start;
    logic [7:0]            tx_data;
    logic                  tx_busy;

    board_cmd_decoder decoder_i (
        .clock         (clock),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_row       (cmd_row),
        .cmd_col       (cmd_col),
        .cmd_value     (cmd_value),
        .sending       (sending),
        .cmd_ready     (cmd_ready),
        .cell_write_en (cell_write_en),
        .cell_index    (cell_index),
        .cell_value    (cell_value),
        .board_clear   (board_clear),
        .send_start    (send_start),
        .cmd_error     (cmd_error)
    );

    board_store store_i (
        .clock         (clock),
        .reset         (reset),
        .cell_write_en (cell_write_en),
        .cell_index    (cell_index),
        .cell_value    (cell_value),
        .board_clear   (board_clear),
        .board         (board)
    );

    board_frame_sender #(
        .EVENT_CODE (EVENT_CODE),
        .PACKET_GAP (PACKET_GAP)
    ) sender_i (
        .clock      (clock),
        .reset      (reset),
        .send_start (send_start),
        .board      (board),
        .tx_busy    (tx_busy),
        .sending    (sending),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .frame_done (frame_done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_tx_i (
        .clock      (clock),
        .reset      (reset),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .tx_busy    (tx_busy),
        .serial_out (serial_out)
    );

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  wire       clock,
    input  wire       reset,
    input  wire       tx_start,
    input  wire [7:0] tx_data,
    output logic      tx_busy,
    output logic      serial_out
);

    localparam int CLK_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        s_idle,
        s_start_bit,
        s_data_bits,
        s_stop_bit
    } state_t;

    state_t           state;
    logic [CLK_W-1:0] clk_count;
    logic [2:0]       bit_index;
    logic [7:0]       data_q;
    logic             bit_done;

    assign bit_done = (clk_count == CLK_W'(CLKS_PER_BIT - 1));
    assign tx_busy  = (state != s_idle);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= s_idle;
            clk_count  <= '0;
            bit_index  <= '0;
            serial_out <= 1'b1;
        end else begin
            case (state)
                s_idle: begin
                    clk_count  <= '0;
                    bit_index  <= '0;
                    serial_out <= 1'b1;
                    if (tx_start) begin
                        serial_out <= 1'b0;  // start bit.
                        state      <= s_start_bit;
                    end
                end
                s_start_bit: begin
                    if (bit_done) begin
                        clk_count  <= '0;
                        serial_out <= data_q[0];
                        state      <= s_data_bits;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                s_data_bits: begin
                    if (bit_done) begin
                        clk_count <= '0;
                        if (bit_index == 3'd7) begin
                            serial_out <= 1'b1;  // stop bit.
                            state      <= s_stop_bit;
                        end else begin
                            bit_index  <= bit_index + 1'b1;
                            serial_out <= data_q[3'(bit_index + 1'b1)];
                        end
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                s_stop_bit: begin
                    if (bit_done) begin
                        clk_count <= '0;
                        state     <= s_idle;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == s_idle && tx_start)
            data_q <= tx_data;
    end

endmodule

`default_nettype wire

// File: verilog/board_frame_sender.sv
`timescale 1ns/10ps
`default_nettype none

module board_frame_sender import board_pkg::*; #(
    parameter logic [7:0] EVENT_CODE = 8'hAC,
    parameter int         PACKET_GAP = 1000  // at least one cycle.
) (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  send_start,
    input  wire [BOARD_BITS-1:0] board,
    input  wire                  tx_busy,
    output logic                 sending,
    output logic                 tx_start,
    output logic [7:0]           tx_data,
    output logic                 frame_done
);

    localparam int SNAP_BITS = 8 * (FRAME_BYTES - 1);
    localparam int PAD_BITS  = SNAP_BITS - BOARD_BITS;
    localparam int GAP_W     = (PACKET_GAP > 1) ? $clog2(PACKET_GAP) : 1;
    localparam int BYTE_W    = $clog2(FRAME_BYTES);

    typedef enum logic [2:0] {
        s_idle,
        s_gap,
        s_prepare,
        s_start,
        s_wait_end,
        s_next
    } state_t;

    state_t              state;
    logic [GAP_W-1:0]    gap_count;
    logic [BYTE_W-1:0]   byte_index;
    logic [SNAP_BITS-1:0] snapshot;
    logic                last_byte;

    assign last_byte = (byte_index == BYTE_W'(FRAME_BYTES - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= s_idle;
            gap_count  <= '0;
            byte_index <= '0;
            sending    <= 1'b0;
            tx_start   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                s_idle: begin
                    tx_start <= 1'b0;
                    if (send_start) begin
                        sending   <= 1'b1;
                        gap_count <= '0;
                        state     <= s_gap;
                    end
                end
                s_gap: begin
                    if (gap_count == GAP_W'(PACKET_GAP - 1)) begin
                        byte_index <= '0;
                        state      <= s_prepare;
                    end else begin
                        gap_count <= gap_count + 1'b1;
                    end
                end
                s_prepare: begin
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        state    <= s_start;
                    end
                end
                s_start: begin
                    // busy is up from the next cycle on.
                    tx_start <= 1'b0;
                    state    <= s_wait_end;
                end
                s_wait_end: begin
                    if (!tx_busy)
                        state <= s_next;
                end
                s_next: begin
                    if (last_byte) begin
                        sending    <= 1'b0;
                        frame_done <= 1'b1;
                        state      <= s_idle;
                    end else begin
                        byte_index <= byte_index + 1'b1;
                        state      <= s_prepare;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // frame payload. snapshot shifts one byte per data byte sent.
    always_ff @(posedge clock) begin
        if (state == s_idle && send_start)
            snapshot <= {{PAD_BITS{1'b0}}, board};
        else if (state == s_next && byte_index != '0)
            snapshot <= snapshot >> 8;

        if (state == s_prepare) begin
            if (byte_index == '0)
                tx_data <= EVENT_CODE;
            else
                tx_data <= {snapshot[3:0], snapshot[7:4]};  // even cell goes high.
        end
    end

    start_when_idle: assert property (@(posedge clock) disable iff (reset)
        tx_start |-> !tx_busy)
        else $error("tx_start issued while transmitter busy");

    no_send_in_frame: assert property (@(posedge clock) disable iff (reset)
        send_start |-> !sending)
        else $error("send_start arrived during a frame");

endmodule

`default_nettype wire

// File: verilog/board_store.sv
`timescale 1ns/10ps
`default_nettype none

module board_store import board_pkg::*; (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   cell_write_en,
    input  wire [6:0]             cell_index,
    input  wire [3:0]             cell_value,
    input  wire                   board_clear,
    output logic [BOARD_BITS-1:0] board
);

    logic [CELL_BITS-1:0] cells [CELL_COUNT];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < CELL_COUNT; i++) begin
                cells[i] <= '0;
            end
        end else if (board_clear) begin
            for (int i = 0; i < CELL_COUNT; i++) begin
                cells[i] <= '0;
            end
        end else if (cell_write_en) begin
            cells[cell_index] <= cell_value;
        end
    end

    // flatten, cell 0 in the low nibble.
    for (genvar i = 0; i < CELL_COUNT; i++) begin : g_cell
        assign board[i*CELL_BITS +: CELL_BITS] = cells[i];
    end

    // decoder range check must keep the index on the board.
    write_in_range: assert property (@(posedge clock) disable iff (reset)
        cell_write_en |-> (cell_index < CELL_COUNT))
        else $error("cell write outside the board, index %0d", cell_index);

endmodule

`default_nettype wire

// File: verilog/board_cmd_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module board_cmd_decoder import board_pkg::*; (
    input  wire          clock,
    input  wire          reset,
    input  wire          cmd_valid,
    input  wire cmd_op_t cmd_op,
    input  wire [3:0]    cmd_row,
    input  wire [3:0]    cmd_col,
    input  wire [3:0]    cmd_value,
    input  wire          sending,
    output logic         cmd_ready,
    output logic         cell_write_en,
    output logic [6:0]   cell_index,
    output logic [3:0]   cell_value,
    output logic         board_clear,
    output logic         send_start,
    output logic         cmd_error
);

    logic       cmd_fire;
    logic       operands_ok;
    logic [6:0] flat_index;

    // a send still in flight to the sender also blocks the port.
    assign cmd_ready = !sending && !send_start;
    assign cmd_fire  = cmd_valid && cmd_ready;

    assign operands_ok = (cmd_row < GRID_ROWS) && (cmd_col < GRID_COLS) &&
                         (cmd_value <= MAX_CELL_VALUE);

    assign flat_index = 7'(cmd_row * GRID_COLS + cmd_col);  // row major.

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cell_write_en <= 1'b0;
            board_clear   <= 1'b0;
            send_start    <= 1'b0;
            cmd_error     <= 1'b0;
        end else begin
            cell_write_en <= 1'b0;
            board_clear   <= 1'b0;
            send_start    <= 1'b0;
            cmd_error     <= 1'b0;
            if (cmd_fire) begin
                case (cmd_op)
                    op_write_cell: begin
                        if (operands_ok)
                            cell_write_en <= 1'b1;
                        else
                            cmd_error <= 1'b1;  // out of range operand.
                    end
                    op_clear_board: board_clear <= 1'b1;
                    op_send_board:  send_start <= 1'b1;
                    default:        cmd_error <= 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cmd_fire) begin
            cell_index <= flat_index;
            cell_value <= cmd_value;
        end
    end

    // each accepted command has a single outcome.
    outcome_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0({cell_write_en, board_clear, send_start, cmd_error}))
        else $error("decoder issued more than one outcome pulse");

endmodule

`default_nettype wire

// File: verilog/board_pkg.sv
`default_nettype none

package board_pkg;

    // board geometry.
    parameter int GRID_ROWS = 9;
    parameter int GRID_COLS = 9;
    parameter int CELL_BITS = 4;
    parameter int CELL_COUNT = GRID_ROWS * GRID_COLS;
    parameter int BOARD_BITS = CELL_COUNT * CELL_BITS;  // cell i at bits 4i+3..4i.

    parameter int MAX_CELL_VALUE = 9;

    // event code byte followed by 41 data bytes.
    parameter int FRAME_BYTES = 42;

    typedef enum logic [1:0] {
        op_write_cell  = 2'd0,
        op_clear_board = 2'd1,
        op_send_board  = 2'd2,
        op_reserved    = 2'd3
    } cmd_op_t;

endpackage

`default_nettype wire
